// ==== Makefile ====
# Verilator build and run of the PWM timer testbench

TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = pwm_tb
FILELIST  = build.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== build.f ====
verilog/pwm_pkg.sv
verilog/pwm_cfg_regs.sv
verilog/pwm_channel.sv
verilog/pwm_top.sv
sim/pwm_asserts.sv
sim/pwm_tb.sv

// ==== sim/pwm_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module pwm_asserts (
	input wire                                          clk_i,
	input wire                                          rst_i,
	input wire                                          wr_ready_i,
	input wire [pwm_pkg::NUM_CH-1:0]                    pwm_i,
	input wire pwm_pkg::pwm_cfg_t [pwm_pkg::NUM_CH-1:0] cfg_i,
	input wire [pwm_pkg::NUM_CH-1:0]                    load_i
);

	import pwm_pkg::*;

	a_ready_rst: assert property (@(posedge clk_i) rst_i |=> !wr_ready_i)
		else $error("wr_ready_o high while reset is asserted");

	for (genvar c = 0; c < NUM_CH; c++) begin : g_ch
		// active config off means a quiet output
		a_off_low: assert property (@(posedge clk_i) disable iff (rst_i)
			(cfg_i[c].mode == MODE_OFF) |-> !pwm_i[c])
			else $error("channel %0d output high while its mode is off", c);

		a_load_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
			load_i[c] |=> !load_i[c])
			else $error("channel %0d load high two cycles in a row", c);
	end

endmodule

`default_nettype wire

// ==== sim/pwm_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pwm_tb;

	import pwm_pkg::*;

	typedef struct packed {
		ch_t       ch;
		pwm_mode_e mode;
		cnt_t      period;
		cnt_t      thr1;
		cnt_t      thr2;
		step_t     step;
		cnt_t      window;     // periods, or pulses in heartbeat mode
		cnt_t      exp_high;   // high cycles over the window
	} test_row_t;

	logic              clk_i;
	logic              rst_i;
	wr_cmd_t           wr_cmd;
	logic              wr_valid;
	wire               wr_ready;
	wire  [NUM_CH-1:0] pwm;

	test_row_t rows [$];
	pwm_cfg_t  model [NUM_CH];   // last value written per channel
	integer    seed;
	int        cycles = 0;
	int        limit  = 0;

	pwm_top dut0 (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.wr_cmd_i   (wr_cmd),
		.wr_valid_i (wr_valid),
		.wr_ready_o (wr_ready),
		.pwm_o      (pwm)
	);

	bind pwm_top pwm_asserts u_asserts (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.wr_ready_i (wr_ready_o),
		.pwm_i      (pwm_o),
		.cfg_i      (cfg),
		.load_i     (load)
	);

	always #10 clk_i = ~clk_i;

	always @(posedge clk_i) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles > limit) begin
			$display("timeout: DUT did not finish within %0d cycles", limit);
			$display("Test failed");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	task automatic stop_run(input string msg);
		$display("error at %0t: %s", $time, msg);
		$display("Test failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_count(input cnt_t got, input cnt_t want, input string what);
		if (got !== want) stop_run($sformatf("%s: got %0d, expected %0d", what, got, want));
	endtask

	task automatic check_bit(input logic got, input logic want, input string what);
		if (got !== want) stop_run($sformatf("%s: got %b, expected %b", what, got, want));
	endtask

	function automatic cnt_t min_cnt(input cnt_t a, input cnt_t b);
		return (a < b) ? a : b;
	endfunction

	// width of pulse k of the heartbeat ramp
	function automatic cnt_t heartbeat_width(input test_row_t r, input int k);
		cnt_t t;
		t = r.thr1;
		for (int i = 0; i < k; i++) begin
			t = t + cnt_t'(r.step);
			if (t > r.thr2) t = r.thr1;   // wrap back to the start
		end
		return min_cnt(t, r.period - 1);
	endfunction

	function automatic test_row_t make_row(input ch_t ch, input pwm_mode_e mode,
			input cnt_t period, input cnt_t thr1, input cnt_t thr2, input step_t step,
			input cnt_t window, input cnt_t exp_high);
		test_row_t r;
		r.ch       = ch;
		r.mode     = mode;
		r.period   = period;
		r.thr1     = thr1;
		r.thr2     = thr2;
		r.step     = step;
		r.window   = window;
		r.exp_high = exp_high;
		return r;
	endfunction

	function automatic int table_cost();
		int c;
		c = 0;
		foreach (rows[i]) c = c + int'((rows[i].window + 3) * rows[i].period);
		return c;
	endfunction

	task automatic send_write(input ch_t ch, input reg_addr_e addr, input cnt_t data);
		logic taken;
		wr_cmd   = '{ch: ch, addr: addr, data: data};
		wr_valid = 1'b1;
		taken    = 1'b0;
		while (!taken) begin
			taken = wr_ready;   // value seen by the next rising edge
			@(negedge clk_i);
		end
		wr_valid = 1'b0;
	endtask

	// writes only changed fields, then waits until they are all active
	task automatic apply_row(input test_row_t r);
		pwm_cfg_t want;
		want.mode   = r.mode;
		want.period = r.period;
		want.thr1   = r.thr1;
		want.thr2   = r.thr2;
		want.step   = r.step;
		if (want.period != model[r.ch].period) send_write(r.ch, REG_PERIOD, want.period);
		if (want.thr1 != model[r.ch].thr1) send_write(r.ch, REG_THR1, want.thr1);
		if (want.thr2 != model[r.ch].thr2) send_write(r.ch, REG_THR2, want.thr2);
		if (want.step != model[r.ch].step) send_write(r.ch, REG_STEP, cnt_t'(want.step));
		if (want.mode != model[r.ch].mode) send_write(r.ch, REG_MODE, cnt_t'(want.mode));
		model[r.ch] = want;
		while (dut0.cfg[r.ch] !== want) @(negedge clk_i);
	endtask

	task automatic wait_rise(input ch_t ch);
		while (pwm[ch] !== 1'b0) @(negedge clk_i);
		while (pwm[ch] !== 1'b1) @(negedge clk_i);
	endtask

	task automatic pulse_width(input ch_t ch, output cnt_t width);
		wait_rise(ch);
		width = 0;
		while (pwm[ch] === 1'b1) begin
			width++;
			@(negedge clk_i);
		end
	endtask

	task automatic count_high(input ch_t ch, input cnt_t span, output cnt_t n);
		n = 0;
		repeat (span) begin
			if (pwm[ch] === 1'b1) n++;
			@(negedge clk_i);
		end
	endtask

	task automatic run_row(input test_row_t r, output cnt_t total);
		cnt_t w;
		cnt_t sum;
		apply_row(r);
		sum = 0;
		case (r.mode)
			MODE_STD: begin
				wait_rise(r.ch);
				count_high(r.ch, r.window * r.period, sum);
			end
			MODE_HEART: begin
				for (int k = 0; k < int'(r.window); k++) begin
					pulse_width(r.ch, w);
					check_count(w, heartbeat_width(r, k),
						$sformatf("heartbeat pulse %0d on channel %0d", k, r.ch));
					sum = sum + w;
				end
			end
			default: count_high(r.ch, r.window * r.period, sum);
		endcase
		check_count(sum, r.exp_high, $sformatf("high count on channel %0d", r.ch));
		total = sum;
	endtask

	task automatic mid_period_update();
		cnt_t n;
		cnt_t w;
		apply_row(make_row(1'b0, MODE_STD, 16, 4, 0, 12'd0, 2, 8));
		wait_rise(1'b0);
		// new duty lands while the pulse is already high
		wr_cmd   = '{ch: 1'b0, addr: REG_THR1, data: 32'd10};
		wr_valid = 1'b1;
		check_bit(wr_ready, 1'b1, "wr_ready while channel 0 runs");
		n = 1;
		@(negedge clk_i);
		wr_valid = 1'b0;
		model[0].thr1 = 32'd10;
		while (pwm[0] === 1'b1) begin
			n++;
			@(negedge clk_i);
		end
		check_count(n, 4, "pulse in progress during the thr1 write");
		pulse_width(1'b0, w);
		check_count(w, 10, "first pulse after the thr1 write");
		wait_rise(1'b0);
		count_high(1'b0, 2 * 16, n);
		check_count(n, 20, "two periods after the thr1 write");
	endtask

	task automatic channel_isolation();
		test_row_t base;
		cnt_t      after;
		base = make_row(1'b0, MODE_STD, 10, 3, 0, 12'd0, 4, 12);
		run_row(base, after);
		run_row(make_row(1'b1, MODE_HEART, 12, 2, 9, 12'd3, 6, 30), after);
		wait_rise(1'b0);
		count_high(1'b0, base.window * base.period, after);
		check_count(after, base.exp_high, "channel 0 count after channel 1 setup");
		run_row(make_row(1'b0, MODE_OFF, 10, 3, 0, 12'd0, 3, 0), after);
	endtask

	initial begin
		cnt_t p;
		cnt_t t1;
		cnt_t got;
		seed     = 32'h2d5bf595;
		clk_i    = 1'b0;
		rst_i    = 1'b1;
		wr_cmd   = '0;
		wr_valid = 1'b0;
		for (int i = 0; i < NUM_CH; i++) model[i] = '0;

		rows.push_back(make_row(1'b0, MODE_STD, 10, 3, 0, 12'd0, 4, 12));
		rows.push_back(make_row(1'b0, MODE_STD, 10, 15, 0, 12'd0, 3, 27));
		rows.push_back(make_row(1'b1, MODE_HEART, 12, 2, 9, 12'd3, 6, 30));
		rows.push_back(make_row(1'b1, MODE_HEART, 6, 3, 8, 12'd2, 4, 16));
		rows.push_back(make_row(1'b1, MODE_STD, 9, 9, 0, 12'd0, 2, 16));
		for (int i = 0; i < 4; i++) begin
			p  = 3 + ($unsigned($random(seed)) % 20);
			t1 = 1 + ($unsigned($random(seed)) % (p + 4));   // may reach past the period
			rows.push_back(make_row(ch_t'(i % 2), MODE_STD, p, t1, 0, 12'd0, 3,
				3 * min_cnt(t1, p - 1)));
		end
		rows.push_back(make_row(1'b1, MODE_OFF, 8, 1, 0, 12'd0, 3, 0));
		limit = 2500 + table_cost();   // margin covers reset and the extra sequences

		repeat (8) @(negedge clk_i);
		check_bit(wr_ready, 1'b0, "wr_ready during reset");
		rst_i = 1'b0;
		@(negedge clk_i);
		check_bit(wr_ready, 1'b1, "wr_ready after reset");
		repeat (40) begin
			check_bit(pwm[0], 1'b0, "channel 0 output after reset");
			check_bit(pwm[1], 1'b0, "channel 1 output after reset");
			@(negedge clk_i);
		end

		foreach (rows[i]) run_row(rows[i], got);
		mid_period_update();
		channel_isolation();

		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/pwm_cfg_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module pwm_cfg_regs (
	input  wire                                     clk_i,
	input  wire                                     rst_i,
	input  wire pwm_pkg::wr_cmd_t                   wr_cmd_i,
	input  wire                                     wr_valid_i,
	output logic                                    wr_ready_o,
	input  wire  [pwm_pkg::NUM_CH-1:0]              period_end_i,
	output pwm_pkg::pwm_cfg_t [pwm_pkg::NUM_CH-1:0] cfg_o,
	output logic [pwm_pkg::NUM_CH-1:0]              load_o
);

	import pwm_pkg::*;

	pwm_cfg_t [NUM_CH-1:0] shadow_q;
	pwm_cfg_t [NUM_CH-1:0] active_q;
	logic [NUM_CH-1:0]     pending_q;   // shadow holds writes not yet active
	logic [NUM_CH-1:0]     load_q;
	logic [NUM_CH-1:0]     wr_hit;
	logic [NUM_CH-1:0]     ch_off;
	logic [NUM_CH-1:0]     commit;
	logic                  ready_q;
	logic                  wr_fire;
	logic                  addr_ok;
	cnt_t                  wr_data;

	// ready drops only during reset
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ready_q <= 1'b0;
		end else begin
			ready_q <= 1'b1;
		end
	end

	assign wr_fire = wr_valid_i & ready_q;
	assign wr_data = wr_cmd_i.data;
	assign addr_ok = (wr_cmd_i.addr <= REG_STEP); // unknown addresses are dropped

	always_comb begin
		for (int c = 0; c < NUM_CH; c++) begin
			wr_hit[c] = wr_fire && addr_ok && (wr_cmd_i.ch == ch_t'(c));

			// mode 3 counts as off here as well
			ch_off[c] = (active_q[c].mode != MODE_STD) &&
				(active_q[c].mode != MODE_HEART);

			// no commit in the load cycle so load stays a single pulse
			commit[c] = pending_q[c] && !load_q[c] && (period_end_i[c] || ch_off[c]);
		end
	end

	// one shadow field per address
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			shadow_q <= '0;
		end else begin
			for (int c = 0; c < NUM_CH; c++) begin
				if (wr_hit[c]) begin
					case (wr_cmd_i.addr)
						REG_MODE:   shadow_q[c].mode   <= pwm_mode_e'(wr_data[1:0]);
						REG_PERIOD: shadow_q[c].period <= wr_data;
						REG_THR1:   shadow_q[c].thr1   <= wr_data;
						REG_THR2:   shadow_q[c].thr2   <= wr_data;
						REG_STEP:   shadow_q[c].step   <= step_t'(wr_data[11:0]);
						default:    ;
					endcase
				end
			end
		end
	end

	// active copy changes only at a period boundary or while off
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			active_q <= '0;   // mode field 0 is off
		end else begin
			for (int c = 0; c < NUM_CH; c++) begin
				if (commit[c]) begin
					active_q[c] <= shadow_q[c];
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			pending_q <= '0;
			load_q    <= '0;
		end else begin
			// a write in the commit cycle stays pending for the next boundary
			pending_q <= (pending_q & ~commit) | wr_hit;
			load_q    <= commit;
		end
	end

	assign wr_ready_o = ready_q;
	assign cfg_o      = active_q;
	assign load_o     = load_q;

endmodule

`default_nettype wire

// ==== verilog/pwm_channel.sv ====
`timescale 1ns/1ps
`default_nettype none

module pwm_channel (
	input  wire                    clk_i,
	input  wire                    rst_i,
	input  wire pwm_pkg::pwm_cfg_t cfg_i,
	input  wire                    load_i,
	output logic                   period_end_o,
	output logic                   pwm_o
);

	import pwm_pkg::*;

	typedef enum logic [1:0] {
		ST_OFF,
		ST_STD,
		ST_HB_FIRST,   // copies thr1 into the running threshold
		ST_HB_RUN
	} state_e;

	state_e state_q;
	state_e state_d;
	state_e load_state;
	cnt_t   cnt_q;
	cnt_t   cnt_d;
	cnt_t   thr_q;     // running heartbeat threshold
	cnt_t   thr_d;
	cnt_t   last_cnt;
	logic   pwm_q;
	logic   pwm_d;
	logic   at_end;
	logic   running;
	logic   hb_wrap;

	assign last_cnt = cfg_i.period - cnt_t'(1);
	assign at_end   = (cnt_q == last_cnt);
	assign running  = (state_q == ST_STD) || (state_q == ST_HB_RUN);

	// threshold went past thr2 at the last period end
	assign hb_wrap = (state_q == ST_HB_RUN) && (thr_q > cfg_i.thr2);

	// entry state for the mode just loaded
	always_comb begin
		case (cfg_i.mode)
			MODE_STD:   load_state = ST_STD;
			MODE_HEART: load_state = ST_HB_FIRST;
			default:    load_state = ST_OFF;   // off and mode 3
		endcase
	end

	always_comb begin
		state_d = state_q;
		cnt_d   = cnt_q;
		thr_d   = thr_q;
		pwm_d   = 1'b0;

		if (load_i) begin
			// restart from the first state of the new mode
			state_d = load_state;
			cnt_d   = '0;
		end else begin
			case (state_q)
				ST_STD: begin
					if (at_end) begin
						cnt_d = '0;   // last cycle of the period stays low
					end else begin
						cnt_d = cnt_q + cnt_t'(1);
						pwm_d = (cnt_q < cfg_i.thr1);
					end
				end

				ST_HB_FIRST: begin
					thr_d   = cfg_i.thr1;
					state_d = ST_HB_RUN;
				end

				ST_HB_RUN: begin
					if (hb_wrap) begin
						// one low cycle before starting over from thr1
						cnt_d = '0;
						thr_d = cfg_i.thr1;
					end else if (at_end) begin
						cnt_d = '0;
						thr_d = thr_q + cnt_t'(cfg_i.step);
					end else begin
						cnt_d = cnt_q + cnt_t'(1);
						pwm_d = (cnt_q < thr_q);
					end
				end

				default: begin
					cnt_d = '0;   // output held low while off
				end
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= ST_OFF;
			cnt_q   <= '0;
			thr_q   <= '0;
			pwm_q   <= 1'b0;
		end else begin
			state_q <= state_d;
			cnt_q   <= cnt_d;
			thr_q   <= thr_d;
			pwm_q   <= pwm_d;
		end
	end

	assign period_end_o = (running && at_end) || hb_wrap;
	assign pwm_o        = pwm_q;

endmodule

`default_nettype wire

// ==== verilog/pwm_pkg.sv ====
`default_nettype none

package pwm_pkg;

	localparam int NUM_CH = 2;
	localparam int CH_W   = 1;

	typedef logic [31:0]     cnt_t;      // periods, thresholds, counters
	typedef logic [11:0]     step_t;     // heartbeat increment
	typedef logic [CH_W-1:0] ch_t;
	typedef logic [2:0]      reg_addr_t;

	// value 3 is unnamed and the channel treats it as off
	typedef enum logic [1:0] {
		MODE_OFF   = 2'd0,
		MODE_STD   = 2'd1,
		MODE_HEART = 2'd2
	} pwm_mode_e;

	typedef enum reg_addr_t {
		REG_MODE   = 3'd0,
		REG_PERIOD = 3'd1,
		REG_THR1   = 3'd2,
		REG_THR2   = 3'd3,
		REG_STEP   = 3'd4
	} reg_addr_e;

	// one channel's configuration for shadow and active copies alike
	typedef struct packed {
		pwm_mode_e mode;
		cnt_t      period;
		cnt_t      thr1;    // duty in std mode, start value in heartbeat
		cnt_t      thr2;    // heartbeat upper limit
		step_t     step;
	} pwm_cfg_t;

	// narrow registers take the low bits of data
	typedef struct packed {
		ch_t       ch;
		reg_addr_t addr;
		cnt_t      data;
	} wr_cmd_t;

endpackage

`default_nettype wire

// ==== verilog/pwm_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pwm_top (
	input  wire                          clk_i,
	input  wire                          rst_i,
	input  wire pwm_pkg::wr_cmd_t        wr_cmd_i,
	input  wire                          wr_valid_i,
	output wire                          wr_ready_o,
	output wire [pwm_pkg::NUM_CH-1:0]    pwm_o
);

	import pwm_pkg::*;

	wire pwm_cfg_t [NUM_CH-1:0] cfg;         // active config per channel
	wire [NUM_CH-1:0]           load;
	wire [NUM_CH-1:0]           period_end;

	pwm_cfg_regs u_regs (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.wr_cmd_i     (wr_cmd_i),
		.wr_valid_i   (wr_valid_i),
		.wr_ready_o   (wr_ready_o),
		.period_end_i (period_end),
		.cfg_o        (cfg),
		.load_o       (load)
	);

	// one generator per channel
	for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
		pwm_channel u_ch (
			.clk_i        (clk_i),
			.rst_i        (rst_i),
			.cfg_i        (cfg[i]),
			.load_i       (load[i]),
			.period_end_o (period_end[i]),
			.pwm_o        (pwm_o[i])
		);
	end

endmodule

`default_nettype wire
